// ==== cache_axi_pkg.sv ====
`default_nettype none

package cache_axi_pkg;

	// one word per beat on both the cache side and AXI
	localparam int CACHE_BUS_DATA_LEN = 32;
	localparam int CACHE_BUS_STRB_LEN = CACHE_BUS_DATA_LEN / 8;

	// port index sits in the low id bits
	localparam int AXI_ID_WIDTH = 4;
	localparam int AXI_ADDR_WIDTH = 32;
	localparam int AXI_LEN_WIDTH = 8;
	localparam logic [1:0] AXI_BURST_INCR = 2'b01;

	// request from one cache port
	typedef struct packed {
		logic                                valid;
		logic                                write;
		logic [3:0]                          burst_size;  // beats minus one
		logic [1:0]                          data_size;   // log2 bytes per beat
		logic                                cached;
		logic [AXI_ADDR_WIDTH-1:0]           addr;
		logic                                data_ok;
		logic                                data_last;
		logic [CACHE_BUS_STRB_LEN-1:0]       data_strobe;
		logic [CACHE_BUS_DATA_LEN-1:0]       w_data;
	} cache_bus_req_t;

	// response back to one cache port
	typedef struct packed {
		logic                                ready;       // single-cycle accept pulse
		logic                                data_ok;
		logic                                data_last;
		logic [CACHE_BUS_DATA_LEN-1:0]       r_data;
	} cache_bus_resp_t;

	// request fields held for the whole transaction
	typedef struct packed {
		logic                                write;
		logic [3:0]                          burst_size;
		logic [1:0]                          data_size;
		logic [AXI_ADDR_WIDTH-1:0]           addr;
	} sel_req_t;

	// live beat fields from the owning port
	typedef struct packed {
		logic                                data_ok;
		logic                                data_last;
		logic [CACHE_BUS_STRB_LEN-1:0]       data_strobe;
		logic [CACHE_BUS_DATA_LEN-1:0]       w_data;
	} sel_data_t;

	// master side of the AXI port
	typedef struct packed {
		logic [AXI_ID_WIDTH-1:0]             ar_id;
		logic [AXI_ADDR_WIDTH-1:0]           ar_addr;
		logic [AXI_LEN_WIDTH-1:0]            ar_len;
		logic [2:0]                          ar_size;
		logic [1:0]                          ar_burst;
		logic                                ar_valid;
		logic [AXI_ID_WIDTH-1:0]             aw_id;
		logic [AXI_ADDR_WIDTH-1:0]           aw_addr;
		logic [AXI_LEN_WIDTH-1:0]            aw_len;
		logic [2:0]                          aw_size;
		logic [1:0]                          aw_burst;
		logic                                aw_valid;
		logic [CACHE_BUS_DATA_LEN-1:0]       w_data;
		logic [CACHE_BUS_STRB_LEN-1:0]       w_strb;
		logic                                w_last;
		logic                                w_valid;
		logic                                r_ready;
		logic                                b_ready;
	} axi_req_t;

	// slave side of the AXI port
	typedef struct packed {
		logic                                ar_ready;
		logic                                aw_ready;
		logic                                w_ready;
		logic [AXI_ID_WIDTH-1:0]             r_id;
		logic [CACHE_BUS_DATA_LEN-1:0]       r_data;
		logic                                r_last;
		logic                                r_valid;
		logic [AXI_ID_WIDTH-1:0]             b_id;
		logic                                b_valid;
	} axi_resp_t;

endpackage

`default_nettype wire

// ==== arbiter_round_robin.sv ====
`timescale 1ns/1ps
`default_nettype none

module arbiter_round_robin #(
	parameter int CACHE_PORT_NUM = 2
) (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire  [CACHE_PORT_NUM-1:0] req_i,
	input  wire                       take_sel_i,
	output logic [CACHE_PORT_NUM-1:0] sel_o
);

	localparam int IDX_W = (CACHE_PORT_NUM > 1) ? $clog2(CACHE_PORT_NUM) : 1;

	// port with the highest priority this cycle
	logic [IDX_W-1:0] prio_ptr;
	logic [IDX_W-1:0] win_idx;
	logic             win_found;

	// scan from the pointer, wrapping past the last port
	always_comb begin
		int unsigned pos;

		sel_o     = '0;
		win_idx   = '0;
		win_found = 1'b0;
		for (int off = 0; off < CACHE_PORT_NUM; off++) begin
			pos = (int'(prio_ptr) + off) % CACHE_PORT_NUM;
			if (!win_found && req_i[pos]) begin
				sel_o[pos] = 1'b1;
				win_idx    = IDX_W'(pos);
				win_found  = 1'b1;
			end
		end
	end

	// winner drops to lowest priority once its grant is taken
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			prio_ptr <= '0;
		end else if (take_sel_i && win_found) begin
			if (win_idx == IDX_W'(CACHE_PORT_NUM - 1)) begin
				prio_ptr <= '0;
			end else begin
				prio_ptr <= win_idx + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== cache_req_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_req_select #(
	parameter int CACHE_PORT_NUM = 2
) (
	input  wire                                                 clk,
	input  wire                                                 rst_n,
	input  wire cache_axi_pkg::cache_bus_req_t [CACHE_PORT_NUM-1:0] req_i,
	input  wire  [CACHE_PORT_NUM-1:0]                           grant_i,
	input  wire                                                 take_i,
	output cache_axi_pkg::sel_req_t                             sel_req_o,
	output logic [CACHE_PORT_NUM-1:0]                           owner_o,
	output logic [cache_axi_pkg::AXI_ID_WIDTH-1:0]              owner_index_o,
	output cache_axi_pkg::sel_data_t                            sel_data_o
);

	cache_axi_pkg::sel_req_t grant_req;

	// grant is one-hot, so OR-ing masked fields gives a mux
	always_comb begin
		grant_req = '0;
		for (int i = 0; i < CACHE_PORT_NUM; i++) begin
			if (grant_i[i]) begin
				grant_req.write      |= req_i[i].write;
				grant_req.burst_size |= req_i[i].burst_size;
				grant_req.data_size  |= req_i[i].data_size;
				grant_req.addr       |= req_i[i].addr;
			end
		end
	end

	// owner is only meaningful once a grant has been taken
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			owner_o <= '0;
		end else if (take_i) begin
			owner_o <= grant_i;
		end
	end

	always_ff @(posedge clk) begin
		if (take_i) begin
			sel_req_o <= grant_req;
		end
	end

	// owner index doubles as the AXI id
	always_comb begin
		owner_index_o = '0;
		for (int i = 0; i < CACHE_PORT_NUM; i++) begin
			if (owner_o[i]) begin
				owner_index_o = cache_axi_pkg::AXI_ID_WIDTH'(i);
			end
		end
	end

	// beat fields stay live from the owning port
	always_comb begin
		sel_data_o = '0;
		for (int i = 0; i < CACHE_PORT_NUM; i++) begin
			if (owner_o[i]) begin
				sel_data_o.data_ok     |= req_i[i].data_ok;
				sel_data_o.data_last   |= req_i[i].data_last;
				sel_data_o.data_strobe |= req_i[i].data_strobe;
				sel_data_o.w_data      |= req_i[i].w_data;
			end
		end
	end

endmodule

`default_nettype wire

// ==== axi_converter.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_converter #(
	parameter int CACHE_PORT_NUM = 2
) (
	input  wire                                                  clk,
	input  wire                                                  rst_n,
	input  wire cache_axi_pkg::cache_bus_req_t [CACHE_PORT_NUM-1:0]  req_i,
	output cache_axi_pkg::cache_bus_resp_t [CACHE_PORT_NUM-1:0]      resp_o,
	output cache_axi_pkg::axi_req_t                              axi_req_o,
	input  wire cache_axi_pkg::axi_resp_t                        axi_resp_i
);

	// one-hot transaction state
	typedef enum logic [3:0] {
		ST_IDLE = 4'b0001,
		ST_ADDR = 4'b0010,
		ST_DATA = 4'b0100,
		ST_RESP = 4'b1000
	} state_t;

	state_t state;
	state_t next_state;

	logic [CACHE_PORT_NUM-1:0]                 req_valid;
	logic [CACHE_PORT_NUM-1:0]                 grant;
	logic [CACHE_PORT_NUM-1:0]                 owner;
	logic [cache_axi_pkg::AXI_ID_WIDTH-1:0]    owner_index;
	cache_axi_pkg::sel_req_t                   sel_req;
	cache_axi_pkg::sel_data_t                  sel_data;

	logic take;
	logic in_data;
	logic is_write;
	logic r_hit;
	logic b_hit;
	logic r_ready;
	logic w_valid;
	logic w_last;
	logic b_ready;
	logic r_fire;
	logic w_fire;
	logic b_fire;
	logic addr_fire;

	always_comb begin
		for (int i = 0; i < CACHE_PORT_NUM; i++) begin
			req_valid[i] = req_i[i].valid;
		end
	end

	arbiter_round_robin #(
		.CACHE_PORT_NUM(CACHE_PORT_NUM)
	) u_arbiter (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_i      (req_valid),
		.take_sel_i (take),
		.sel_o      (grant)
	);

	cache_req_select #(
		.CACHE_PORT_NUM(CACHE_PORT_NUM)
	) u_req_select (
		.clk           (clk),
		.rst_n         (rst_n),
		.req_i         (req_i),
		.grant_i       (grant),
		.take_i        (take),
		.sel_req_o     (sel_req),
		.owner_o       (owner),
		.owner_index_o (owner_index),
		.sel_data_o    (sel_data)
	);

	assign take     = (state == ST_IDLE);
	assign in_data  = (state == ST_DATA);
	assign is_write = sel_req.write;

	// only beats tagged with the owner's id belong to this transaction
	assign r_hit = axi_resp_i.r_valid && (axi_resp_i.r_id == owner_index);
	assign b_hit = axi_resp_i.b_valid && (axi_resp_i.b_id == owner_index);

	// the cache paces beats in both directions through its data_ok
	assign r_ready = in_data & ~is_write & sel_data.data_ok;
	assign w_valid = in_data & is_write & sel_data.data_ok;
	assign w_last  = in_data & is_write & sel_data.data_last;
	assign b_ready = (state == ST_RESP);

	assign r_fire    = r_hit & r_ready;
	assign w_fire    = w_valid & axi_resp_i.w_ready;
	assign b_fire    = b_hit & b_ready;
	assign addr_fire = is_write ? axi_resp_i.aw_ready : axi_resp_i.ar_ready;

	always_comb begin
		next_state = state;
		case (state)
			ST_IDLE: begin
				if (|grant) begin
					next_state = ST_ADDR;
				end
			end
			ST_ADDR: begin
				if (addr_fire) begin
					next_state = ST_DATA;
				end
			end
			ST_DATA: begin
				if (r_fire && axi_resp_i.r_last) begin
					next_state = ST_IDLE;
				end else if (w_fire && w_last) begin
					next_state = ST_RESP;
				end
			end
			ST_RESP: begin
				if (b_fire) begin
					next_state = ST_IDLE;
				end
			end
			default: begin
				next_state = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ST_IDLE;
		end else begin
			state <= next_state;
		end
	end

	// ready pulses in the grant cycle, beats go only to the owner
	always_comb begin
		for (int i = 0; i < CACHE_PORT_NUM; i++) begin
			resp_o[i].ready     = grant[i] & take;
			resp_o[i].data_ok   = owner[i] & (is_write ? w_fire : r_fire);
			resp_o[i].data_last = owner[i] & ~is_write & r_fire & axi_resp_i.r_last;
			resp_o[i].r_data    = axi_resp_i.r_data;
		end
	end

	always_comb begin
		axi_req_o = '0;

		axi_req_o.ar_id    = owner_index;
		axi_req_o.ar_addr  = sel_req.addr;
		axi_req_o.ar_len   = cache_axi_pkg::AXI_LEN_WIDTH'(sel_req.burst_size);
		axi_req_o.ar_size  = {1'b0, sel_req.data_size};
		axi_req_o.ar_burst = cache_axi_pkg::AXI_BURST_INCR;
		axi_req_o.ar_valid = (state == ST_ADDR) & ~is_write;

		axi_req_o.aw_id    = owner_index;
		axi_req_o.aw_addr  = sel_req.addr;
		axi_req_o.aw_len   = cache_axi_pkg::AXI_LEN_WIDTH'(sel_req.burst_size);
		axi_req_o.aw_size  = {1'b0, sel_req.data_size};
		axi_req_o.aw_burst = cache_axi_pkg::AXI_BURST_INCR;
		axi_req_o.aw_valid = (state == ST_ADDR) & is_write;

		// write data passes straight through from the owner
		axi_req_o.w_data  = sel_data.w_data;
		axi_req_o.w_strb  = sel_data.data_strobe;
		axi_req_o.w_last  = w_last;
		axi_req_o.w_valid = w_valid;

		axi_req_o.r_ready = r_ready;
		axi_req_o.b_ready = b_ready;
	end

endmodule

`default_nettype wire

// ==== cache_axi_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_axi_top #(
	parameter int CACHE_PORT_NUM = 2
) (
	input  wire                                                  clk,
	input  wire                                                  rst_n,
	input  wire cache_axi_pkg::cache_bus_req_t [CACHE_PORT_NUM-1:0]  cache_req_i,
	output cache_axi_pkg::cache_bus_resp_t [CACHE_PORT_NUM-1:0]      cache_resp_o,
	output cache_axi_pkg::axi_req_t                              axi_req_o,
	input  wire cache_axi_pkg::axi_resp_t                        axi_resp_i
);

	// all cache ports share the single AXI master
	axi_converter #(
		.CACHE_PORT_NUM(CACHE_PORT_NUM)
	) u_converter (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_i      (cache_req_i),
		.resp_o     (cache_resp_o),
		.axi_req_o  (axi_req_o),
		.axi_resp_i (axi_resp_i)
	);

endmodule

`default_nettype wire

// ==== tb_axi_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem (
	input  wire                            clk,
	input  wire                            rst_n,
	input  wire                            stall_en_i,
	input  wire cache_axi_pkg::axi_req_t   axi_req_i,
	output cache_axi_pkg::axi_resp_t       axi_resp_o
);

	logic [31:0] mem [0:255];
	int          seed = 32'h4d14_6571;
	logic        rd_act, wr_act, b_pend, r_take, b_take;
	logic [3:0]  rd_id, wr_id;
	logic [7:0]  rd_idx, wr_idx, rd_left;

	// every byte depends on the whole word index
	initial begin
		for (int i = 0; i < 256; i++) begin
			mem[i] = {8'(i) ^ 8'ha5, 8'(i * 7), ~8'(i), 8'(i)};
		end
	end

	// go most cycles, stall about a quarter of them when enabled
	function automatic logic roll();
		return !stall_en_i || (($random(seed) & 3) != 0);
	endfunction

	// handshakes are sampled at the rising edge
	always @(posedge clk) begin
		if (!rst_n) begin
			rd_act <= 1'b0;
			wr_act <= 1'b0;
			b_pend <= 1'b0;
			r_take <= 1'b0;
			b_take <= 1'b0;
		end else begin
			r_take <= axi_resp_o.r_valid && axi_req_i.r_ready;
			b_take <= axi_resp_o.b_valid && axi_req_i.b_ready;
			if (axi_req_i.ar_valid && axi_resp_o.ar_ready) begin
				rd_act  <= 1'b1;
				rd_id   <= axi_req_i.ar_id;
				rd_idx  <= axi_req_i.ar_addr[9:2];
				rd_left <= axi_req_i.ar_len;
			end
			if (axi_resp_o.r_valid && axi_req_i.r_ready) begin
				rd_idx  <= rd_idx + 1'b1;
				rd_left <= rd_left - 1'b1;
				if (rd_left == 0) begin
					rd_act <= 1'b0;
				end
			end
			if (axi_req_i.aw_valid && axi_resp_o.aw_ready) begin
				wr_act <= 1'b1;
				wr_id  <= axi_req_i.aw_id;
				wr_idx <= axi_req_i.aw_addr[9:2];
			end
			if (axi_req_i.w_valid && axi_resp_o.w_ready) begin
				for (int b = 0; b < 4; b++) begin
					if (axi_req_i.w_strb[b]) begin
						mem[wr_idx][8*b +: 8] <= axi_req_i.w_data[8*b +: 8];
					end
				end
				wr_idx <= wr_idx + 1'b1;
				if (axi_req_i.w_last) begin
					wr_act <= 1'b0;
					b_pend <= 1'b1;
				end
			end
			if (axi_resp_o.b_valid && axi_req_i.b_ready) begin
				b_pend <= 1'b0;
			end
		end
	end

	// outputs change on the falling edge, valid holds until taken
	always @(negedge clk) begin
		if (!rst_n) begin
			axi_resp_o = '0;
		end else begin
			axi_resp_o.ar_ready = !rd_act && !wr_act && !b_pend && roll();
			axi_resp_o.aw_ready = !rd_act && !wr_act && !b_pend && roll();
			axi_resp_o.w_ready  = wr_act && roll();
			if (!axi_resp_o.r_valid || r_take) begin
				axi_resp_o.r_valid = rd_act && roll();
			end
			axi_resp_o.r_id   = rd_id;
			axi_resp_o.r_data = mem[rd_idx];
			axi_resp_o.r_last = (rd_left == 0);
			if (!axi_resp_o.b_valid || b_take) begin
				axi_resp_o.b_valid = b_pend && roll();
			end
			axi_resp_o.b_id = wr_id;
		end
	end

endmodule

`default_nettype wire

// ==== tb_cache_axi.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cache_axi;

	logic clk, rst_n, stall_en, gaps_on, busy;
	cache_axi_pkg::cache_bus_req_t  [1:0] creq;
	cache_axi_pkg::cache_bus_resp_t [1:0] cresp;
	cache_axi_pkg::axi_req_t              axi_req;
	cache_axi_pkg::axi_resp_t             axi_resp;
	int          errs, mon_errs, cycles, owner_port, n_pass, n_fail, t_errs;
	int          seed = 32'h4d14_6571;
	int          grant_log[$];
	int          id_log[$];
	logic [31:0] model [0:255];
	logic [31:0] ar_addr_q;
	logic [7:0]  ar_len_q;
	logic [2:0]  ar_size_q;
	logic [1:0]  ar_burst_q;
	logic [3:0]  ar_id_q;
	logic [31:0] aw_addr_q;
	logic [7:0]  aw_len_q;
	logic [2:0]  aw_size_q;
	logic [1:0]  aw_burst_q;

	cache_axi_top #(.CACHE_PORT_NUM(2)) u_dut (
		.clk(clk), .rst_n(rst_n), .cache_req_i(creq), .cache_resp_o(cresp),
		.axi_req_o(axi_req), .axi_resp_i(axi_resp)
	);

	tb_axi_mem u_mem (
		.clk(clk), .rst_n(rst_n), .stall_en_i(stall_en),
		.axi_req_i(axi_req), .axi_resp_o(axi_resp)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic report_err(input string msg);
		errs++;
		$display("ERR %0t: %s", $time, msg);
	endtask

	task automatic report_order(input string msg);
		mon_errs++;
		report_err(msg);
	endtask

	// address channels must hold valid and fields while stalled
	ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(axi_req.ar_valid && !axi_resp.ar_ready) |=> (axi_req.ar_valid
		&& $stable(axi_req.ar_addr) && $stable(axi_req.ar_len) && $stable(axi_req.ar_id)))
		else report_err("AR dropped or changed before ar_ready");
	aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(axi_req.aw_valid && !axi_resp.aw_ready) |=> (axi_req.aw_valid
		&& $stable(axi_req.aw_addr) && $stable(axi_req.aw_len) && $stable(axi_req.aw_id)))
		else report_err("AW dropped or changed before aw_ready");

	// transaction ownership tracked from the cache side
	always @(posedge clk) begin
		cycles++;
		if (cycles >= 4000) begin
			$display("timeout: the run did not finish within 4000 cycles");
			$display("RESULT: FAIL");
			$finish;
		end else if (rst_n) begin
			for (int p = 0; p < 2; p++) begin
				if (cresp[p].data_ok || cresp[p].data_last) begin
					assert (busy && owner_port == p) else report_order("beat to a non-owner port");
				end
				if (cresp[p].ready) begin
					assert (!busy) else report_order("ready pulse during an open transaction");
					assert (creq[p].valid) else report_order("grant to a port without valid");
					grant_log.push_back(p);
					busy = 1'b1;
					owner_port = p;
				end
			end
			if (axi_resp.r_valid && axi_req.r_ready) begin
				assert (axi_resp.r_id == owner_port) else report_order("R beat id is not the owner");
				if (axi_resp.r_last) busy = 1'b0;
			end
			if (axi_resp.b_valid && axi_req.b_ready) begin
				assert (axi_resp.b_id == owner_port) else report_order("B beat id is not the owner");
				busy = 1'b0;
			end
			if (axi_req.ar_valid && axi_resp.ar_ready) begin
				{ar_addr_q, ar_len_q, ar_size_q, ar_burst_q, ar_id_q} =
					{axi_req.ar_addr, axi_req.ar_len, axi_req.ar_size, axi_req.ar_burst,
					axi_req.ar_id};
				id_log.push_back(axi_req.ar_id);
			end
			if (axi_req.aw_valid && axi_resp.aw_ready) begin
				assert (axi_req.aw_id == owner_port) else report_err("AW id is not the owner");
				{aw_addr_q, aw_len_q, aw_size_q, aw_burst_q} =
					{axi_req.aw_addr, axi_req.aw_len, axi_req.aw_size, axi_req.aw_burst};
				id_log.push_back(axi_req.aw_id);
			end
		end
	end

	task automatic check_idle_outputs();
		assert (!axi_req.ar_valid && !axi_req.aw_valid && !axi_req.w_valid
			&& !axi_req.r_ready && !axi_req.b_ready) else report_err("AXI valid/ready high in reset");
		for (int p = 0; p < 2; p++) begin
			assert (!cresp[p].ready && !cresp[p].data_ok && !cresp[p].data_last)
				else report_err("cache response strobe high in reset");
		end
	endtask

	// called on a falling edge so valid rises right away
	task automatic raise_request(input int port, input logic wr, input logic [31:0] addr,
			input logic [3:0] bs);
		creq[port].valid      = 1'b1;
		creq[port].write      = wr;
		creq[port].addr       = addr;
		creq[port].burst_size = bs;
		creq[port].data_size  = 2'd2;
		do @(posedge clk); while (!cresp[port].ready);
		@(negedge clk);
		creq[port].valid = 1'b0;
	endtask

	task automatic run_read(input int port, input logic [31:0] addr, input logic [3:0] bs);
		int beat;
		int word;
		beat = 0;
		raise_request(port, 1'b0, addr, bs);
		while (beat <= bs) begin
			creq[port].data_ok = !gaps_on || ($random(seed) & 1);
			@(posedge clk);
			if (cresp[port].data_ok) begin
				word = ((addr >> 2) + beat) & 255;
				assert (cresp[port].r_data == model[word]) else report_err("read data mismatch");
				assert (cresp[port].data_last == (beat == bs)) else report_err("data_last misplaced");
				beat++;
			end
			@(negedge clk);
		end
		creq[port].data_ok = 1'b0;
	endtask

	task automatic run_write(input int port, input logic [31:0] addr, input logic [3:0] bs,
			input int tag);
		int beat;
		int word;
		logic [31:0] d;
		logic [3:0] s;
		beat = 0;
		raise_request(port, 1'b1, addr, bs);
		while (beat <= bs) begin
			d = 32'hc0de_0000 + tag * 256 + beat;
			s = (beat % 4 == 0) ? 4'hf : (beat % 4 == 1) ? 4'h3 : (beat % 4 == 2) ? 4'hc : 4'h5;
			creq[port].data_ok     = !gaps_on || ($random(seed) & 1);
			creq[port].data_last   = (beat == bs);
			creq[port].w_data      = d;
			creq[port].data_strobe = s;
			@(posedge clk);
			if (cresp[port].data_ok) begin
				assert (axi_req.w_data == d && axi_req.w_strb == s) else report_err("W beat mismatch");
				assert (axi_req.w_last == (beat == bs)) else report_err("w_last misplaced");
				word = ((addr >> 2) + beat) & 255;
				for (int b = 0; b < 4; b++) begin
					if (s[b]) model[word][8*b +: 8] = d[8*b +: 8];
				end
				beat++;
			end
			@(negedge clk);
		end
		creq[port].data_ok   = 1'b0;
		creq[port].data_last = 1'b0;
	endtask

	task automatic finish_test(input int num, input string name, input int failures);
		if (failures == 0) begin
			n_pass++;
			$display("test %0d %s: ok", num, name);
		end else begin
			n_fail++;
			$display("test %0d %s: failed with %0d errors", num, name, failures);
		end
	endtask

	initial begin
		{errs, mon_errs, cycles, owner_port, n_pass, n_fail} = '0;
		{rst_n, stall_en, gaps_on, busy} = '0;
		creq = '0;
		for (int i = 0; i < 256; i++) begin
			model[i] = {8'(i) ^ 8'ha5, 8'(i * 7), ~8'(i), 8'(i)};
		end
		@(posedge clk);
		repeat (4) begin
			@(posedge clk);
			check_idle_outputs();
		end
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_idle_outputs();
		finish_test(1, "reset state", errs);

		t_errs = errs;
		run_read(0, 32'h0000_0020, 4'd3);
		// INCR burst is encoded as 2'b01
		assert (ar_addr_q == 32'h20 && ar_len_q == 8'd3 && ar_size_q == 3'd2
			&& ar_burst_q == 2'b01 && ar_id_q == 0)
			else report_err("AR fields differ from the request");
		finish_test(2, "read burst", errs - t_errs);

		t_errs = errs;
		run_write(1, 32'h0000_0040, 4'd3, 1);
		assert (aw_addr_q == 32'h40 && aw_len_q == 8'd3 && aw_size_q == 3'd2
			&& aw_burst_q == 2'b01)
			else report_err("AW fields differ from the request");
		run_read(1, 32'h0000_0040, 4'd3);
		finish_test(3, "write burst with strobes", errs - t_errs);

		t_errs = errs;
		grant_log.delete();
		id_log.delete();
		fork
			for (int k = 0; k < 3; k++) run_read(0, 32'h100 + k * 16, 4'd1);
			for (int k = 0; k < 3; k++) run_write(1, 32'h200 + k * 16, 4'd1, 2 + k);
		join
		assert (grant_log.size() == 6 && id_log.size() == 6) else report_err("wrong grant count");
		for (int i = 0; i < grant_log.size() && i < id_log.size(); i++) begin
			assert (id_log[i] == grant_log[i]) else report_err("address id does not follow grant");
			if (i > 0) begin
				assert (grant_log[i] != grant_log[i-1]) else report_err("grants not alternating");
			end
		end
		finish_test(4, "round-robin fairness", errs - t_errs);

		t_errs = errs;
		stall_en = 1'b1;
		gaps_on  = 1'b1;
		run_read(0, 32'h0000_0020, 4'd3);
		run_write(1, 32'h0000_0080, 4'd7, 9);
		run_read(0, 32'h0000_0080, 4'd7);
		run_read(1, 32'h0000_0040, 4'd3);
		finish_test(5, "back-pressure", errs - t_errs);

		finish_test(6, "one transaction at a time", mon_errs);
		$display("tests passed %0d failed %0d, errors %0d", n_pass, n_fail, errs);
		if (errs == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
cache_axi_pkg.sv
arbiter_round_robin.sv
cache_req_select.sv
axi_converter.sv
cache_axi_top.sv
tb_axi_mem.sv
tb_cache_axi.sv
